/* Makefile */
# Verilator flow for the comp subsystem
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= tb_comp
RTL_TOP   ?= comp
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/addr_dec.sv */
`timescale 1ns/1ns
`default_nettype none
`include "comp_consts.svh"

module addr_dec import comp_pkg::*; (
   input  wire          clk,
   input  wire          reset,
   input  wire wb_req_t wb_req,
   output region_e      region,
   input  wire wb_rsp_t mem_rsp,
   input  wire wb_rsp_t tmr_rsp,
   input  wire wb_rsp_t gpio_rsp,
   output wb_rsp_t      wb_rsp
);

   logic [3:0] top;
   logic [3:0] io_field;
   logic       none_go;
   logic       none_ack;   // own ack for unmapped space
   logic       none_done;

   assign top      = wb_req.adr[`COMP_ADR_BITS-1 -: 4];
   assign io_field = wb_req.adr[11:8];

   always_comb begin
      if (top == 4'h0)
         region = REGION_MEM;
      else if (top == `REGION_IO) begin
         case (io_field)
            `IO_TIMER: region = REGION_TIMER;
            `IO_GPIO:  region = REGION_GPIO;
            default:   region = REGION_NONE;
         endcase
      end else
         region = REGION_NONE;
   end

   assign none_go = (region == REGION_NONE) && wb_req.cyc && wb_req.stb
                    && !none_ack && !none_done;

   always_ff @(posedge clk) begin
      if (reset) begin
         none_ack  <= 1'b0;
         none_done <= 1'b0;
      end else begin
         none_ack  <= none_go;   // writes dropped
         none_done <= wb_req.stb && (none_done || none_ack);
      end
   end

   // response of the selected slave back to the master
   always_comb begin
      case (region)
         REGION_MEM:   wb_rsp = mem_rsp;
         REGION_TIMER: wb_rsp = tmr_rsp;
         REGION_GPIO:  wb_rsp = gpio_rsp;
         default:      wb_rsp = '{ack: none_ack, dat: '0};
      endcase
   end

   a_one_ack: assert property (@(posedge clk) disable iff (reset)
      $onehot0({mem_rsp.ack, tmr_rsp.ack, gpio_rsp.ack, none_ack}));

   a_ack_cyc: assert property (@(posedge clk) disable iff (reset)
      wb_rsp.ack |-> wb_req.cyc);

endmodule

`default_nettype wire

/* hdl/comp.sv */
`timescale 1ns/1ns
`default_nettype none
`include "comp_consts.svh"

module comp import comp_pkg::*; (
   input  wire                      clk,
   input  wire                      reset,
   input  wire wb_req_t             wb_req,
   output wb_rsp_t                  wb_rsp,
   // ports
   input  wire [`COMP_WIDTH-1:0]    porti,
   input  wire [`COMP_WIDTH-1:0]    portj,
   output logic [`COMP_WIDTH-1:0]   porta,
   output logic [`COMP_WIDTH-1:0]   portb,
   output logic [`COMP_WIDTH-1:0]   portc,
   output logic [`COMP_WIDTH-1:0]   portd,
   output logic [31:0]              irqs
);

   region_e region;
   wb_rsp_t mem_rsp;
   wb_rsp_t tmr_rsp;
   wb_rsp_t gpio_rsp;
   logic    sel_mem;
   logic    sel_tmr;
   logic    sel_gpio;
   logic    irq_timer;

   addr_dec adec (
      .clk      (clk),
      .reset    (reset),
      .wb_req   (wb_req),
      .region   (region),
      .mem_rsp  (mem_rsp),
      .tmr_rsp  (tmr_rsp),
      .gpio_rsp (gpio_rsp),
      .wb_rsp   (wb_rsp)
   );

   assign sel_mem  = (region == REGION_MEM);
   assign sel_tmr  = (region == REGION_TIMER);
   assign sel_gpio = (region == REGION_GPIO);

   memory #(.ADDR_SIZE(`MEM_ADDR_SIZE)) mem (
      .clk    (clk),
      .reset  (reset),
      .sel    (sel_mem),
      .wb_req (wb_req),
      .wb_rsp (mem_rsp)
   );

   timer tmr1 (
      .clk    (clk),
      .reset  (reset),
      .sel    (sel_tmr),
      .wb_req (wb_req),
      .wb_rsp (tmr_rsp),
      .irq    (irq_timer)
   );

   gpio gpio_i (
      .clk    (clk),
      .reset  (reset),
      .sel    (sel_gpio),
      .wb_req (wb_req),
      .wb_rsp (gpio_rsp),
      .porti  (porti),
      .portj  (portj),
      .porta  (porta),
      .portb  (portb),
      .portc  (portc),
      .portd  (portd)
   );

   assign irqs = {31'd0, irq_timer};   // only the timer is live

endmodule

`default_nettype wire

/* hdl/comp_consts.svh */
`ifndef COMP_CONSTS_SVH
`define COMP_CONSTS_SVH

// data path
`define COMP_WIDTH      32
`define COMP_ADR_BITS   16   // word address

// word memory
`define MEM_ADDR_SIZE   10   // 1024 words

// address map, top nibble of the word address
// a top nibble of 0 selects the memory
`define REGION_IO       4'hF

// i/o field, address bits 11:8
`define IO_TIMER        4'h0
`define IO_GPIO         4'h1

`endif

/* hdl/comp_pkg.sv */
`default_nettype none
`include "comp_consts.svh"

package comp_pkg;

   typedef struct packed {
      logic                      cyc;
      logic                      stb;
      logic                      we;
      logic [`COMP_ADR_BITS-1:0] adr;
      logic [`COMP_WIDTH-1:0]    dat;
   } wb_req_t;

   typedef struct packed {
      logic                   ack;
      logic [`COMP_WIDTH-1:0] dat;
   } wb_rsp_t;

   typedef enum logic [1:0] {
      REGION_MEM,
      REGION_TIMER,
      REGION_GPIO,
      REGION_NONE
   } region_e;

   // timer registers, adr[2:0]
   typedef enum logic [2:0] {
      TMR_CTRL  = 3'd0,
      TMR_PRESC = 3'd1,
      TMR_ARR   = 3'd2,
      TMR_CTR   = 3'd3,
      TMR_STAT  = 3'd4
   } timer_reg_e;

   // gpio registers, adr[2:0]
   typedef enum logic [2:0] {
      GPIO_I = 3'd0,
      GPIO_J = 3'd1,
      GPIO_A = 3'd2,
      GPIO_B = 3'd3,
      GPIO_C = 3'd4,
      GPIO_D = 3'd5
   } gpio_reg_e;

endpackage

`default_nettype wire

/* hdl/gpio.sv */
`timescale 1ns/1ns
`default_nettype none
`include "comp_consts.svh"

module gpio import comp_pkg::*; (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      sel,
   input  wire wb_req_t             wb_req,
   output wb_rsp_t                  wb_rsp,
   input  wire [`COMP_WIDTH-1:0]    porti,
   input  wire [`COMP_WIDTH-1:0]    portj,
   output logic [`COMP_WIDTH-1:0]   porta,
   output logic [`COMP_WIDTH-1:0]   portb,
   output logic [`COMP_WIDTH-1:0]   portc,
   output logic [`COMP_WIDTH-1:0]   portd
);

   logic                   go;
   logic                   wr;
   logic                   ack;
   logic                   done;
   logic [`COMP_WIDTH-1:0] rdata;
   logic [`COMP_WIDTH-1:0] i_meta;
   logic [`COMP_WIDTH-1:0] i_sync;
   logic [`COMP_WIDTH-1:0] j_meta;
   logic [`COMP_WIDTH-1:0] j_sync;
   gpio_reg_e              reg_sel;

   assign go      = sel && wb_req.cyc && wb_req.stb && !ack && !done;
   assign wr      = go && wb_req.we;
   assign reg_sel = gpio_reg_e'(wb_req.adr[2:0]);

   // two-flop synchronisers on the input pins
   always_ff @(posedge clk) begin
      i_meta <= porti;
      i_sync <= i_meta;
      j_meta <= portj;
      j_sync <= j_meta;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ack  <= 1'b0;
         done <= 1'b0;
      end else begin
         ack  <= go;
         done <= wb_req.stb && (done || ack);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         porta <= '0;
         portb <= '0;
         portc <= '0;
         portd <= '0;
      end else if (wr) begin
         case (reg_sel)
            GPIO_A:  porta <= wb_req.dat;
            GPIO_B:  portb <= wb_req.dat;
            GPIO_C:  portc <= wb_req.dat;
            GPIO_D:  portd <= wb_req.dat;
            default: ;   // inputs are read only
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (go) begin
         case (reg_sel)
            GPIO_I:  rdata <= i_sync;
            GPIO_J:  rdata <= j_sync;
            GPIO_A:  rdata <= porta;
            GPIO_B:  rdata <= portb;
            GPIO_C:  rdata <= portc;
            GPIO_D:  rdata <= portd;
            default: rdata <= '0;
         endcase
      end
   end

   assign wb_rsp = '{ack: ack, dat: rdata};

   // a held stb gets no second ack
   a_ack_once: assert property (@(posedge clk) disable iff (reset)
      ack ##1 wb_req.stb |=> !ack);

endmodule

`default_nettype wire

/* hdl/memory.sv */
`timescale 1ns/1ns
`default_nettype none
`include "comp_consts.svh"

module memory import comp_pkg::*; #(
   parameter int ADDR_SIZE = `MEM_ADDR_SIZE
) (
   input  wire          clk,
   input  wire          reset,
   input  wire          sel,
   input  wire wb_req_t wb_req,
   output wb_rsp_t      wb_rsp
);

   logic [`COMP_WIDTH-1:0] mem [2**ADDR_SIZE];
   logic [`COMP_WIDTH-1:0] rdata;
   logic [ADDR_SIZE-1:0]   idx;
   logic                   go;
   logic                   ack;
   logic                   done;   // ack given, waiting for stb low

   assign idx = wb_req.adr[ADDR_SIZE-1:0];
   assign go  = sel && wb_req.cyc && wb_req.stb && !ack && !done;

   always_ff @(posedge clk) begin
      if (reset) begin
         ack  <= 1'b0;
         done <= 1'b0;
      end else begin
         ack  <= go;
         done <= wb_req.stb && (done || ack);
      end
   end

   // write lands on the ack edge
   always_ff @(posedge clk) begin
      if (go) begin
         if (wb_req.we)
            mem[idx] <= wb_req.dat;
         rdata <= mem[idx];
      end
   end

   assign wb_rsp = '{ack: ack, dat: rdata};

   a_no_repeat: assert property (@(posedge clk) disable iff (reset)
      ack ##1 wb_req.stb ##1 wb_req.stb |-> !ack);

endmodule

`default_nettype wire

/* hdl/timer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "comp_consts.svh"

module timer import comp_pkg::*; (
   input  wire          clk,
   input  wire          reset,
   input  wire          sel,
   input  wire wb_req_t wb_req,
   output wb_rsp_t      wb_rsp,
   output logic         irq
);

   logic                   go;
   logic                   wr;
   logic                   ack;
   logic                   done;
   logic [`COMP_WIDTH-1:0] rdata;
   logic [1:0]             ctrl;      // bit 0 enable, bit 1 irq enable
   logic [`COMP_WIDTH-1:0] presc;
   logic [`COMP_WIDTH-1:0] arr;
   logic [`COMP_WIDTH-1:0] ctr;
   logic [`COMP_WIDTH-1:0] psc;       // prescale count
   logic                   reached;
   logic                   tick;
   timer_reg_e             reg_sel;

   assign go      = sel && wb_req.cyc && wb_req.stb && !ack && !done;
   assign wr      = go && wb_req.we;
   assign reg_sel = timer_reg_e'(wb_req.adr[2:0]);
   assign tick    = ctrl[0] && (psc >= presc);

   always_ff @(posedge clk) begin
      if (reset) begin
         ack  <= 1'b0;
         done <= 1'b0;
      end else begin
         ack  <= go;
         done <= wb_req.stb && (done || ack);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ctrl    <= '0;
         presc   <= '0;
         arr     <= '0;
         ctr     <= '0;
         psc     <= '0;
         reached <= 1'b0;
      end else begin
         psc <= (ctrl[0] && !tick) ? psc + 1'b1 : '0;
         if (tick) begin
            // auto-reload at ARR
            if (ctr == arr) begin
               ctr     <= '0;
               reached <= 1'b1;
            end else
               ctr <= ctr + 1'b1;
         end
         if (wr) begin
            case (reg_sel)
               TMR_CTRL:  ctrl  <= wb_req.dat[1:0];
               TMR_PRESC: presc <= wb_req.dat;
               TMR_ARR:   arr   <= wb_req.dat;
               TMR_CTR:   ctr   <= wb_req.dat;   // direct load
               TMR_STAT: begin
                  if (wb_req.dat[0])
                     reached <= 1'b0;             // write 1 to clear
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (go) begin
         case (reg_sel)
            TMR_CTRL:  rdata <= {{(`COMP_WIDTH-2){1'b0}}, ctrl};
            TMR_PRESC: rdata <= presc;
            TMR_ARR:   rdata <= arr;
            TMR_CTR:   rdata <= ctr;
            TMR_STAT:  rdata <= {{(`COMP_WIDTH-1){1'b0}}, reached};
            default:   rdata <= '0;
         endcase
      end
   end

   assign wb_rsp = '{ack: ack, dat: rdata};
   assign irq    = reached && ctrl[1];

   a_ctr_range: assert property (@(posedge clk) disable iff (reset)
      ctrl[0] && (arr != '0) && (ctr <= arr) && !wr |=> ctr <= arr);

endmodule

`default_nettype wire

/* sim/tb_comp.sv */
`timescale 1ns/1ns
`default_nettype none
`include "comp_consts.svh"

module tb_comp import comp_pkg::*; ();

   localparam int CLK_HALF   = 2;
   localparam int RESET_CYC  = 10;
   localparam int ACK_LIMIT  = 8;
   localparam int PIN_SETTLE = 3;
   localparam int PRESC_VAL  = 1;
   localparam int ARR_VAL    = 5;
   localparam int POLL_LIMIT = (ARR_VAL + 1) * (PRESC_VAL + 1) + 20;

   localparam logic [15:0] TMR_BASE   = {`REGION_IO, `IO_TIMER, 8'h00};
   localparam logic [15:0] GPIO_BASE  = {`REGION_IO, `IO_GPIO, 8'h00};
   localparam logic [15:0] NONE_ADR   = 16'h5000;   // low bits alias word 0
   localparam logic [15:0] IO_GAP_ADR = {`REGION_IO, 4'h2, 8'h00};
   localparam logic [15:0] LAST_WORD  = 16'(2**`MEM_ADDR_SIZE - 1);

   typedef enum {K_WRITE, K_READ, K_POLL} kind_e;
   typedef enum {W_NONE, W_PORTA, W_PORTB, W_PORTC, W_PORTD, W_IRQS} watch_e;

   typedef struct {
      string       name;
      kind_e       kind;
      logic [15:0] adr;
      logic [31:0] wdat;
      logic [31:0] exp;
      logic [31:0] pin_i;
      logic [31:0] pin_j;
      watch_e      watch;      // pin to compare besides bus data
      logic [31:0] watch_exp;
   } entry_t;

   logic        clk;
   logic        reset;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic [31:0] porti;
   logic [31:0] portj;
   logic [31:0] porta;
   logic [31:0] portb;
   logic [31:0] portc;
   logic [31:0] portd;
   logic [31:0] irqs;

   entry_t      tests[$];
   logic [31:0] next_i;        // pins for entries being added
   logic [31:0] next_j;
   int          cycles = 0;
   int          limit = 0;
   int          passed;
   int          errors;

   comp comp_i (
      .clk    (clk),
      .reset  (reset),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp),
      .porti  (porti),
      .portj  (portj),
      .porta  (porta),
      .portb  (portb),
      .portc  (portc),
      .portd  (portd),
      .irqs   (irqs)
   );

   always #CLK_HALF clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("Finished with errors");
         $finish;
      end
   end

   function automatic void write_step(string name, logic [15:0] adr, logic [31:0] dat);
      tests.push_back('{name: name, kind: K_WRITE, adr: adr, wdat: dat, exp: '0,
                        pin_i: next_i, pin_j: next_j, watch: W_NONE, watch_exp: '0});
   endfunction

   function automatic void check_step(string name, logic [15:0] adr, logic [31:0] exp,
                                      watch_e watch, logic [31:0] watch_exp);
      tests.push_back('{name: name, kind: K_READ, adr: adr, wdat: '0, exp: exp,
                        pin_i: next_i, pin_j: next_j, watch: watch, watch_exp: watch_exp});
   endfunction

   function automatic void poll_step(string name, logic [15:0] adr, logic [31:0] exp);
      tests.push_back('{name: name, kind: K_POLL, adr: adr, wdat: '0, exp: exp,
                        pin_i: next_i, pin_j: next_j, watch: W_NONE, watch_exp: '0});
   endfunction

   function automatic void build_table();
      logic [15:0] adrs [4];
      logic [31:0] vals [4];
      logic [31:0] outs [4];
      string       ports [4];
      int          k;
      adrs  = '{16'h0000, 16'h0001, 16'h0155, LAST_WORD};
      outs  = '{32'h1111_A0A0, 32'h2222_B1B1, 32'h3333_C2C2, 32'h4444_D3D3};
      ports = '{"a", "b", "c", "d"};
      for (k = 0; k < 4; k++)
         vals[k] = $urandom;
      for (k = 0; k < 4; k++)   // outputs straight out of reset
         check_step($sformatf("port%s_reset", ports[k]), GPIO_BASE + 16'(int'(GPIO_A) + k),
                    '0, watch_e'(int'(W_PORTA) + k), '0);
      for (k = 0; k < 4; k++)
         write_step($sformatf("mem_wr_%h", adrs[k]), adrs[k], vals[k]);
      for (k = 0; k < 4; k++)
         check_step($sformatf("mem_rd_%h", adrs[k]), adrs[k], vals[k], W_NONE, '0);
      for (k = 0; k < 4; k++)
         write_step($sformatf("port%s_wr", ports[k]), GPIO_BASE + 16'(int'(GPIO_A) + k), outs[k]);
      for (k = 0; k < 4; k++)
         check_step($sformatf("port%s_rd", ports[k]), GPIO_BASE + 16'(int'(GPIO_A) + k),
                    outs[k], watch_e'(int'(W_PORTA) + k), outs[k]);
      next_i = 32'hCAFE_0123;
      next_j = 32'h0BAD_F00D;
      check_step("porti_fixed", GPIO_BASE + 16'(GPIO_I), next_i, W_NONE, '0);
      check_step("portj_fixed", GPIO_BASE + 16'(GPIO_J), next_j, W_NONE, '0);
      write_step("porti_wr_ignored", GPIO_BASE + 16'(GPIO_I), 32'h0);
      check_step("porti_after_wr", GPIO_BASE + 16'(GPIO_I), next_i, W_NONE, '0);
      next_i = $urandom;
      next_j = $urandom;
      check_step("porti_random", GPIO_BASE + 16'(GPIO_I), next_i, W_NONE, '0);
      check_step("portj_random", GPIO_BASE + 16'(GPIO_J), next_j, W_NONE, '0);
      // timer, reached after (ARR+1)*(PRESC+1) cycles
      check_step("tmr_idle", TMR_BASE + 16'(TMR_STAT), '0, W_IRQS, '0);
      write_step("tmr_presc", TMR_BASE + 16'(TMR_PRESC), 32'(PRESC_VAL));
      check_step("tmr_presc_rd", TMR_BASE + 16'(TMR_PRESC), 32'(PRESC_VAL), W_NONE, '0);
      write_step("tmr_arr", TMR_BASE + 16'(TMR_ARR), 32'(ARR_VAL));
      write_step("tmr_enable", TMR_BASE + 16'(TMR_CTRL), 32'h3);
      poll_step("tmr_reached", TMR_BASE + 16'(TMR_STAT), 32'h1);
      write_step("tmr_stop", TMR_BASE + 16'(TMR_CTRL), 32'h2);   // irq enable kept
      check_step("tmr_irq_set", TMR_BASE + 16'(TMR_STAT), 32'h1, W_IRQS, 32'h1);
      write_step("tmr_clear", TMR_BASE + 16'(TMR_STAT), 32'h1);
      check_step("tmr_irq_clr", TMR_BASE + 16'(TMR_STAT), '0, W_IRQS, '0);
      // unmapped space
      check_step("none_rd", NONE_ADR, '0, W_NONE, '0);
      check_step("io_gap_rd", IO_GAP_ADR, '0, W_NONE, '0);
      write_step("none_wr", NONE_ADR, ~vals[0]);
      check_step("none_rd_again", NONE_ADR, '0, W_NONE, '0);
      check_step("mem0_kept", 16'h0000, vals[0], W_NONE, '0);
   endfunction

   function automatic bit compare_value(string name, string what, logic [31:0] exp,
                                        logic [31:0] act);
      if (act !== exp) begin
         $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
         errors++;
         return 1'b0;
      end
      return 1'b1;
   endfunction

   function automatic logic [31:0] watch_value(watch_e w);
      case (w)
         W_PORTA: return porta;
         W_PORTB: return portb;
         W_PORTC: return portc;
         W_PORTD: return portd;
         W_IRQS:  return irqs;
         default: return '0;
      endcase
   endfunction

   // one classic cycle, entered and left on a falling edge
   task automatic wb_transfer(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat, output logic acked);
      int n;
      n = 0;
      acked = 1'b0;
      rdat = '0;
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      while (!acked && n < ACK_LIMIT) begin
         @(negedge clk);
         n++;
         if (wb_rsp.ack) begin
            acked = 1'b1;
            rdat = wb_rsp.dat;
         end
      end
      if (acked)
         @(negedge clk);   // held through the edge that takes the ack
      wb_req = '0;
      @(negedge clk);   // stb low for a cycle
   endtask

   task automatic run_test(entry_t t);
      logic [31:0] rdat;
      logic        acked;
      bit          ok;
      int          start;
      ok = 1'b1;
      if (t.pin_i !== porti || t.pin_j !== portj) begin
         porti = t.pin_i;
         portj = t.pin_j;
         repeat (PIN_SETTLE) @(negedge clk);
      end
      start = cycles;
      case (t.kind)
         K_WRITE: wb_transfer(1'b1, t.adr, t.wdat, rdat, acked);
         K_READ: begin
            wb_transfer(1'b0, t.adr, '0, rdat, acked);
            if (acked && !compare_value(t.name, "data", t.exp, rdat))
               ok = 1'b0;
            if (acked && t.watch != W_NONE &&
                !compare_value(t.name, "pins", t.watch_exp, watch_value(t.watch)))
               ok = 1'b0;
         end
         default: begin
            rdat = '0;
            acked = 1'b1;
            while (acked && rdat !== t.exp && cycles - start <= POLL_LIMIT)
               wb_transfer(1'b0, t.adr, '0, rdat, acked);
            if (acked && rdat !== t.exp) begin
               $display("%s: value %h never read within %0d cycles", t.name, t.exp, POLL_LIMIT);
               errors++;
               ok = 1'b0;
            end
         end
      endcase
      if (!acked) begin
         $display("no ack for %s", t.name);
         errors++;
         ok = 1'b0;
      end
      if (ok) begin
         passed++;
         $display("pass %s", t.name);
      end
   endtask

   initial begin
      void'($urandom(77));
      clk    = 1'b0;
      reset  = 1'b1;
      wb_req = '0;
      porti  = '0;
      portj  = '0;
      next_i = '0;
      next_j = '0;
      passed = 0;
      errors = 0;
      build_table();
      limit = tests.size() * ACK_LIMIT + POLL_LIMIT + 100;
      repeat (RESET_CYC) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      foreach (tests[k])
         run_test(tests[k]);
      $display("tests passed: %0d, errors: %0d", passed, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/comp_pkg.sv
hdl/addr_dec.sv
hdl/memory.sv
hdl/timer.sv
hdl/gpio.sv
hdl/comp.sv
sim/tb_comp.sv
